// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    localparam int ISA_WIDTH           = 32;   // data and instruction width
    localparam int REG_FILE_ADDR_WIDTH = 5;    // register index width
    localparam int ADDRESS_WIDTH       = 26;   // j / jal target field
    localparam int LINK_REG            = 31;   // jal writes the return address here

    typedef enum logic [5:0] {
        op_rtype = 6'h00,                       // decoded further by funct
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    // operation handed to execute
    typedef enum logic [2:0] {
        alu_add = 3'd0,                         // also address calc and pc + 4
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5                          // operand 2 shifted into upper half
    } alu_op_t;

endpackage

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic [isa_pkg::ISA_WIDTH-1:0] id_instruction,        // fetched instruction
    output logic                          i_type_instruction,    // any I type, incl lw/sw/beq/bne
    output logic                          r_type_instruction,    // arithmetic R type, not jr
    output logic                          j_instruction,
    output logic                          jr_instruction,
    output logic                          jal_instruction,
    output logic                          branch_instruction,    // beq or bne
    output logic                          store_instruction,
    output logic                          load_instruction,
    output isa_pkg::alu_op_t              alu_op,                // for execute
    output logic                          reg_write,             // instruction writes a register
    output logic [isa_pkg::ISA_WIDTH-1:0] id_sign_extend_result  // extended 16 bit immediate
);
    import isa_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    zero_extend;

    assign opcode      = opcode_t'(id_instruction[31:26]);
    assign funct       = funct_t'(id_instruction[5:0]);
    assign zero_extend = opcode inside {op_andi, op_ori, op_lui};  // logical immediates

    assign id_sign_extend_result = zero_extend ?
        {{(ISA_WIDTH-16){1'b0}}, id_instruction[15:0]} :
        {{(ISA_WIDTH-16){id_instruction[15]}}, id_instruction[15:0]};

    always_comb begin
        i_type_instruction = 1'b0;              // unknown code falls through as a no-op
        r_type_instruction = 1'b0;
        j_instruction      = 1'b0;
        jr_instruction     = 1'b0;
        jal_instruction    = 1'b0;
        branch_instruction = 1'b0;
        store_instruction  = 1'b0;
        load_instruction   = 1'b0;
        reg_write          = 1'b0;
        alu_op             = alu_add;
        case (opcode)
            op_rtype: begin
                r_type_instruction = (funct inside {fn_add, fn_sub, fn_and, fn_or, fn_slt});
                jr_instruction     = (funct == fn_jr);
                reg_write          = r_type_instruction;  // jr writes nothing
                case (funct)
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: alu_op = alu_add;
                endcase
            end
            op_addi, op_slti, op_andi, op_ori, op_lui, op_lw: begin
                i_type_instruction = 1'b1;
                reg_write          = 1'b1;
                load_instruction   = (opcode == op_lw);
            end
            op_sw: begin
                i_type_instruction = 1'b1;
                store_instruction  = 1'b1;
            end
            op_beq, op_bne: begin
                i_type_instruction = 1'b1;
                branch_instruction = 1'b1;
                alu_op             = alu_sub;   // compare passed on as a subtract
            end
            op_j:    j_instruction = 1'b1;
            op_jal: begin
                jal_instruction = 1'b1;
                reg_write       = 1'b1;         // link written via pc + 4
            end
            default: ;
        endcase
        case (opcode)                           // alu override for immediate forms
            op_slti: alu_op = alu_slt;
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_lui:  alu_op = alu_lui;
            default: ;
        endcase
    end

    // redirect sources are exclusive
    always_comb begin
        assert ($onehot0({j_instruction, jal_instruction, jr_instruction}))
            else $error("control_unit: more than one jump class decoded");
    end

endmodule

// ==== rtl/general_reg.sv ====
`timescale 1ns/1ps

module general_reg (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] rs_idx,   // instruction rs field
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] rt_idx,   // instruction rt field
    input  logic                                   wb_we,    // write-back enable
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] wb_idx,
    input  logic [isa_pkg::ISA_WIDTH-1:0]           wb_data,
    output logic [isa_pkg::ISA_WIDTH-1:0]           id_reg_1, // value of rs
    output logic [isa_pkg::ISA_WIDTH-1:0]           id_reg_2  // value of rt
);
    import isa_pkg::*;

    logic [ISA_WIDTH-1:0] regs [0:(1 << REG_FILE_ADDR_WIDTH)-1];
    logic                 wb_live;

    assign wb_live = wb_we && (wb_idx != '0);  // writes to r0 are dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << REG_FILE_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-through so decode sees this cycle's write-back
    assign id_reg_1 = (rs_idx == '0) ? '0 : (wb_live && wb_idx == rs_idx) ? wb_data : regs[rs_idx];
    assign id_reg_2 = (rt_idx == '0) ? '0 : (wb_live && wb_idx == rt_idx) ? wb_data : regs[rt_idx];

    // r0 stays zero whatever write-back did before
    assert property (@(posedge clk) disable iff (rst) (rs_idx == '0) |-> (id_reg_1 == '0))
        else $error("general_reg: r0 read nonzero");

endmodule

// ==== rtl/condition_check.sv ====
`timescale 1ns/1ps

module condition_check (
    input  isa_pkg::opcode_t              opcode,              // primary opcode field
    input  logic                          branch_instruction,  // beq or bne decoded
    input  logic [isa_pkg::ISA_WIDTH-1:0] id_reg_1,            // rs value
    input  logic [isa_pkg::ISA_WIDTH-1:0] id_reg_2,            // rt value
    output logic                          condition_satisfied  // branch is taken
);
    import isa_pkg::*;

    logic regs_equal;

    assign regs_equal = (id_reg_1 == id_reg_2);

    always_comb begin
        condition_satisfied = 1'b0;
        if (branch_instruction) begin
            case (opcode)
                op_beq:  condition_satisfied = regs_equal;
                op_bne:  condition_satisfied = !regs_equal;
                default: condition_satisfied = 1'b0;
            endcase
        end
    end

endmodule

// ==== rtl/signal_mux.sv ====
`timescale 1ns/1ps

module signal_mux (
    input  logic i_type_instruction,    // from control_unit
    input  logic r_type_instruction,
    input  logic j_instruction,
    input  logic jr_instruction,
    input  logic jal_instruction,
    input  logic branch_instruction,
    input  logic store_instruction,
    input  logic condition_satisfied,   // from condition_check
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_reg_1,              // rs value
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_reg_2,              // rt value
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_pc,
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_instruction,
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_sign_extend_result,
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] id_reg_1_idx,          // rs field
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] id_reg_2_idx,          // rt field
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] id_reg_dest_idx,       // rd field
    output logic                                    pc_offset,             // taken branch to fetch
    output logic                                    pc_overload,           // jump to fetch
    output logic [isa_pkg::ISA_WIDTH-1:0]           pc_overload_value,     // jump target
    output logic [isa_pkg::ISA_WIDTH-1:0]           mux_operand_1,
    output logic [isa_pkg::ISA_WIDTH-1:0]           mux_operand_2,         // also branch offset
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_1_idx,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_2_idx,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_dest_idx,
    output logic                                    reg_1_valid,           // rs is a real source
    output logic                                    reg_2_valid            // rt is a real source
);
    import isa_pkg::*;

    logic no_dest;                                  // store or branch
    logic j_type_direct;                            // j or jal, target in the word

    assign no_dest       = store_instruction | branch_instruction;
    assign j_type_direct = j_instruction | jal_instruction;

    assign reg_1_valid = r_type_instruction | i_type_instruction | jr_instruction;
    assign reg_2_valid = r_type_instruction | no_dest;   // sw data, branch compare

    assign pc_offset   = condition_satisfied & branch_instruction;
    assign pc_overload = j_type_direct | jr_instruction;
    assign pc_overload_value = j_type_direct ?
        {id_pc[ISA_WIDTH-1:ADDRESS_WIDTH+2], id_instruction[ADDRESS_WIDTH-1:0], 2'b00} :
        id_reg_1;                                   // jr jumps to rs

    assign mux_operand_1 = jal_instruction ? id_pc : id_reg_1;
    assign mux_operand_2 = i_type_instruction ? id_sign_extend_result :
                           jal_instruction    ? ISA_WIDTH'(4)         : id_reg_2;

    assign mux_reg_1_idx = reg_1_valid ? id_reg_1_idx : '0;  // unused source reads as r0
    assign mux_reg_2_idx = reg_2_valid ? id_reg_2_idx : '0;

    always_comb begin
        if (no_dest)                 mux_reg_dest_idx = '0;
        else if (i_type_instruction) mux_reg_dest_idx = id_reg_2_idx;  // rt
        else if (jal_instruction)    mux_reg_dest_idx = REG_FILE_ADDR_WIDTH'(LINK_REG);
        else if (r_type_instruction) mux_reg_dest_idx = id_reg_dest_idx;  // rd
        else                         mux_reg_dest_idx = '0;  // j, jr and no-ops
    end

    // fetch gets one redirect kind at a time
    always_comb begin
        assert (!(pc_offset && pc_overload))
            else $error("signal_mux: branch and jump redirect together");
    end

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_1_idx,    // decode source 1
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_2_idx,    // decode source 2
    input  logic                                    reg_1_valid,
    input  logic                                    reg_2_valid,
    input  logic                                    ex_mem_read,      // lw sitting in execute
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_dest_idx,  // its destination
    output logic                                    stall             // hold decode a cycle
);

    logic hit_1;
    logic hit_2;

    assign hit_1 = reg_1_valid && (mux_reg_1_idx == ex_reg_dest_idx);
    assign hit_2 = reg_2_valid && (mux_reg_2_idx == ex_reg_dest_idx);

    // load result is not ready for forwarding yet
    assign stall = ex_mem_read && (ex_reg_dest_idx != '0) && (hit_1 || hit_2);

    always_comb begin
        assert (!stall || ex_mem_read)
            else $error("hazard_unit: stall without a load in execute");
    end

endmodule

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    stall,            // load a bubble
    input  logic [isa_pkg::ISA_WIDTH-1:0]           mux_operand_1,
    input  logic [isa_pkg::ISA_WIDTH-1:0]           mux_operand_2,
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_1_idx,
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_2_idx,
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] mux_reg_dest_idx,
    input  isa_pkg::alu_op_t                        alu_op,
    input  logic                                    reg_write,
    input  logic                                    mem_read,         // lw
    input  logic                                    mem_write,        // sw
    output logic [isa_pkg::ISA_WIDTH-1:0]           ex_operand_1,
    output logic [isa_pkg::ISA_WIDTH-1:0]           ex_operand_2,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_1_idx,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_2_idx,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_dest_idx,
    output isa_pkg::alu_op_t                        ex_alu_op,
    output logic                                    ex_reg_write,
    output logic                                    ex_mem_read,
    output logic                                    ex_mem_write
);
    import isa_pkg::*;

    always_ff @(posedge clk) begin
        if (rst || stall) begin                 // bubble is a clean no-op
            ex_operand_1    <= '0;
            ex_operand_2    <= '0;
            ex_reg_1_idx    <= '0;
            ex_reg_2_idx    <= '0;
            ex_reg_dest_idx <= '0;
            ex_alu_op       <= alu_add;
            ex_reg_write    <= 1'b0;
            ex_mem_read     <= 1'b0;
            ex_mem_write    <= 1'b0;
        end else begin
            ex_operand_1    <= mux_operand_1;
            ex_operand_2    <= mux_operand_2;
            ex_reg_1_idx    <= mux_reg_1_idx;
            ex_reg_2_idx    <= mux_reg_2_idx;
            ex_reg_dest_idx <= mux_reg_dest_idx;
            ex_alu_op       <= alu_op;
            ex_reg_write    <= reg_write;
            ex_mem_read     <= mem_read;
            ex_mem_write    <= mem_write;
        end
    end

    // a stalled slot never writes back
    assert property (@(posedge clk) disable iff (rst) stall |=> !ex_reg_write)
        else $error("id_ex_reg: bubble carried a register write");

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_instruction,     // from fetch
    input  logic [isa_pkg::ISA_WIDTH-1:0]           id_pc,
    input  logic                                    wb_we,              // write-back port
    input  logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] wb_idx,
    input  logic [isa_pkg::ISA_WIDTH-1:0]           wb_data,
    output logic                                    pc_offset,          // redirect to fetch
    output logic                                    pc_overload,
    output logic [isa_pkg::ISA_WIDTH-1:0]           pc_overload_value,
    output logic [isa_pkg::ISA_WIDTH-1:0]           pc_offset_value,
    output logic                                    stall,
    output logic [isa_pkg::ISA_WIDTH-1:0]           ex_operand_1,       // to execute
    output logic [isa_pkg::ISA_WIDTH-1:0]           ex_operand_2,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_1_idx,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_2_idx,
    output logic [isa_pkg::REG_FILE_ADDR_WIDTH-1:0] ex_reg_dest_idx,
    output isa_pkg::alu_op_t                        ex_alu_op,
    output logic                                    ex_reg_write,
    output logic                                    ex_mem_read,
    output logic                                    ex_mem_write
);
    import isa_pkg::*;

    logic i_type, r_type, j_ins, jr_ins, jal_ins, branch, store, load;
    alu_op_t                      alu_op;
    logic                         reg_write, condition_satisfied, reg_1_valid, reg_2_valid;
    logic [ISA_WIDTH-1:0]           extended_imm, id_reg_1, id_reg_2, mux_operand_1;
    logic [REG_FILE_ADDR_WIDTH-1:0] mux_reg_1_idx, mux_reg_2_idx, mux_reg_dest_idx;

    control_unit u_control (.id_instruction, .i_type_instruction(i_type),
        .r_type_instruction(r_type), .j_instruction(j_ins), .jr_instruction(jr_ins),
        .jal_instruction(jal_ins), .branch_instruction(branch), .store_instruction(store),
        .load_instruction(load), .alu_op, .reg_write, .id_sign_extend_result(extended_imm));

    general_reg u_regs (.clk, .rst, .rs_idx(id_instruction[25:21]),
        .rt_idx(id_instruction[20:16]), .wb_we, .wb_idx, .wb_data, .id_reg_1, .id_reg_2);

    condition_check u_cond (.opcode(opcode_t'(id_instruction[31:26])),
        .branch_instruction(branch), .id_reg_1, .id_reg_2, .condition_satisfied);

    // operand 2 is also the branch offset seen by fetch
    signal_mux u_mux (.i_type_instruction(i_type), .r_type_instruction(r_type),
        .j_instruction(j_ins), .jr_instruction(jr_ins), .jal_instruction(jal_ins),
        .branch_instruction(branch), .store_instruction(store), .condition_satisfied,
        .id_reg_1, .id_reg_2, .id_pc, .id_instruction, .id_sign_extend_result(extended_imm),
        .id_reg_1_idx(id_instruction[25:21]), .id_reg_2_idx(id_instruction[20:16]),
        .id_reg_dest_idx(id_instruction[15:11]), .pc_offset, .pc_overload, .pc_overload_value,
        .mux_operand_1, .mux_operand_2(pc_offset_value), .mux_reg_1_idx, .mux_reg_2_idx,
        .mux_reg_dest_idx, .reg_1_valid, .reg_2_valid);

    hazard_unit u_hazard (.mux_reg_1_idx, .mux_reg_2_idx, .reg_1_valid, .reg_2_valid,
        .ex_mem_read, .ex_reg_dest_idx, .stall);

    id_ex_reg u_id_ex (.clk, .rst, .stall, .mux_operand_1, .mux_operand_2(pc_offset_value),
        .mux_reg_1_idx, .mux_reg_2_idx, .mux_reg_dest_idx, .alu_op, .reg_write,
        .mem_read(load), .mem_write(store), .ex_operand_1, .ex_operand_2, .ex_reg_1_idx,
        .ex_reg_2_idx, .ex_reg_dest_idx, .ex_alu_op, .ex_reg_write, .ex_mem_read, .ex_mem_write);

endmodule

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;
    import isa_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 2000;
    localparam int WATCHDOG_NS  = 2 * (NUM_INSTR + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {                     // one decode/execute register slot
        logic [31:0] op1, op2;
        logic [4:0]  idx1, idx2, dest;
        logic [2:0]  alu;
        logic        rw, mr, mw;
    } ex_slot_t;

    logic        clk;
    logic        rst = 1'b1;
    logic [31:0] id_instruction = '0, id_pc = '0, wb_data = '0;
    logic        wb_we = 1'b0;
    logic [4:0]  wb_idx = '0;
    logic        pc_offset, pc_overload, stall, ex_reg_write, ex_mem_read, ex_mem_write;
    logic [31:0] pc_overload_value, pc_offset_value, ex_operand_1, ex_operand_2;
    logic [4:0]  ex_reg_1_idx, ex_reg_2_idx, ex_reg_dest_idx;
    alu_op_t     ex_alu_op;

    integer      seed = 96;
    logic [31:0] rnd;
    logic [31:0] shadow [0:31] = '{default: '0};   // model register file, clear like reset
    ex_slot_t    dec;                               // model decode of the current inputs
    ex_slot_t    exp_ex = '0;                       // slot the dut took at the last edge
    logic        d_offset, d_overload;
    logic        d_stall = 1'b0;
    logic [31:0] d_target;
    logic [4:0]  lw_dest = '0;                      // rt of the last issued lw, 0 if none
    int          issued = 0;
    int          stall_count = 0;
    logic [11:0] codes [0:19] = '{                  // {opcode, funct} pool, lw listed twice
        {op_rtype, fn_add}, {op_rtype, fn_sub}, {op_rtype, fn_and}, {op_rtype, fn_or},
        {op_rtype, fn_slt}, {op_rtype, fn_jr}, {op_addi, 6'h0}, {op_slti, 6'h0},
        {op_andi, 6'h0}, {op_ori, 6'h0}, {op_lui, 6'h0}, {op_lw, 6'h0}, {op_lw, 6'h0},
        {op_sw, 6'h0}, {op_beq, 6'h0}, {op_bne, 6'h0}, {op_j, 6'h0}, {op_jal, 6'h0},
        {6'h3e, 6'h0}, {op_rtype, 6'h3f}};          // last two are outside the subset

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin                               // watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired: the decode stage run hung and did not reach its end");
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h (instruction %h, pc %h)",
                     name, expected, actual, id_instruction, id_pc);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] read_shadow(input logic [4:0] idx);
        if (idx == 5'd0) return 32'd0;                  // r0 hard-wired
        if (wb_we && wb_idx == idx) return wb_data;     // same-cycle write-through
        return shadow[idx];
    endfunction

    // expected decode of whatever sits on the inputs right now
    task automatic decode_model();
        logic [5:0]  op, fn;
        logic [4:0]  rs, rt;
        logic [31:0] r1, r2, imm;
        logic        is_r, is_jr, is_imm, is_sw, is_br, is_jal, v1, v2;
        {op, rs, rt} = id_instruction[31:16];
        fn  = id_instruction[5:0];
        r1  = read_shadow(rs);
        r2  = read_shadow(rt);
        imm = {{16{id_instruction[15]}}, id_instruction[15:0]};
        if (op inside {op_andi, op_ori, op_lui}) imm[31:16] = 16'h0;   // logical forms
        is_r   = op == op_rtype && fn inside {fn_add, fn_sub, fn_and, fn_or, fn_slt};
        is_jr  = op == op_rtype && fn == fn_jr;
        is_imm = op inside {op_addi, op_slti, op_andi, op_ori, op_lui, op_lw};  // write rt
        is_sw  = op == op_sw;
        is_br  = op == op_beq || op == op_bne;
        is_jal = op == op_jal;
        v1 = is_r || is_jr || is_imm || is_sw || is_br;
        v2 = is_r || is_sw || is_br;            // sw data and branch compare use rt
        dec.op1  = is_jal ? id_pc : r1;         // jal links pc + 4
        dec.op2  = (is_imm || is_sw || is_br) ? imm : is_jal ? 32'd4 : r2;
        dec.idx1 = v1 ? rs : 5'd0;
        dec.idx2 = v2 ? rt : 5'd0;
        dec.dest = is_imm ? rt : is_jal ? 5'd31 : is_r ? id_instruction[15:11] : 5'd0;
        dec.rw   = is_r || is_imm || is_jal;
        dec.mr   = op == op_lw;
        dec.mw   = is_sw;
        dec.alu  = alu_add;                     // also jr, jal, lw, sw and no-ops
        if (is_br || (is_r && fn == fn_sub)) dec.alu = alu_sub;
        if (op == op_andi || (is_r && fn == fn_and)) dec.alu = alu_and;
        if (op == op_ori || (is_r && fn == fn_or)) dec.alu = alu_or;
        if (op == op_slti || (is_r && fn == fn_slt)) dec.alu = alu_slt;
        if (op == op_lui) dec.alu = alu_lui;
        d_offset   = (op == op_beq && r1 == r2) || (op == op_bne && r1 != r2);
        d_overload = is_jr || is_jal || op == op_j;
        d_target   = is_jr ? r1 : {id_pc[31:28], id_instruction[25:0], 2'b00};
        d_stall    = exp_ex.mr && exp_ex.dest != 5'd0 &&     // load still in execute
                     ((v1 && rs == exp_ex.dest) || (v2 && rt == exp_ex.dest));
    endtask

    task automatic pick_instruction();
        logic [11:0] code;
        int          k;
        rnd  = $random(seed);
        k    = {$random(seed)} % 20;
        code = codes[k];
        id_instruction = {code[11:6], rnd[25:0]};
        if (code[11:6] == op_rtype) id_instruction[5:0] = code[5:0];
        if (rnd[31]) id_instruction[25:11] = id_instruction[25:11] & 15'b00011_00011_00011;
        if (lw_dest != 5'd0 && rnd[30]) id_instruction[25:21] = lw_dest;  // load-use try
        lw_dest = (code[11:6] == op_lw) ? id_instruction[20:16] : 5'd0;
        id_pc = $random(seed);
    endtask

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        while (issued < NUM_INSTR) begin
            if (!d_stall) begin                 // stalled instruction is held upstream
                pick_instruction();
                issued++;
            end
            rnd     = $random(seed);
            wb_we   = rnd[31];
            wb_idx  = rnd[30] ? rnd[4:0] : {3'b000, rnd[1:0]};    // low indices, r0 too
            wb_data = $random(seed);
            #(CLK_PERIOD / 2);                  // mid-cycle, everything settled
            decode_model();
            compare_value("pc_offset", 32'(d_offset), 32'(pc_offset));
            compare_value("pc_overload", 32'(d_overload), 32'(pc_overload));
            compare_value("pc_offset_value", dec.op2, pc_offset_value);
            if (d_overload) compare_value("pc_overload_value", d_target, pc_overload_value);
            compare_value("stall", 32'(d_stall), 32'(stall));
            compare_value("ex_operand_1", exp_ex.op1, ex_operand_1);
            compare_value("ex_operand_2", exp_ex.op2, ex_operand_2);
            compare_value("ex_reg_1_idx", 32'(exp_ex.idx1), 32'(ex_reg_1_idx));
            compare_value("ex_reg_2_idx", 32'(exp_ex.idx2), 32'(ex_reg_2_idx));
            compare_value("ex_reg_dest_idx", 32'(exp_ex.dest), 32'(ex_reg_dest_idx));
            compare_value("ex_alu_op", 32'(exp_ex.alu), 32'(ex_alu_op));
            compare_value("ex_controls", 32'({exp_ex.rw, exp_ex.mr, exp_ex.mw}),
                          32'({ex_reg_write, ex_mem_read, ex_mem_write}));
            if (d_stall) stall_count++;
            exp_ex = d_stall ? '0 : dec;        // bubble on stall
            if (wb_we && wb_idx != 5'd0) shadow[wb_idx] = wb_data;
            @(posedge clk);
            #2;
        end
        if (stall_count > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("no load-use stall happened in %0d instructions", issued);
            $display("TESTBENCH FAILED");
            $fatal(1, "hazard path never exercised");
        end
    end

endmodule

// ==== sources.f ====
rtl/isa_pkg.sv
rtl/control_unit.sv
rtl/general_reg.sv
rtl/condition_check.sv
rtl/signal_mux.sv
rtl/hazard_unit.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
verification/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module decode_stage_tb -f sources.f \
    -o decode_stage_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/decode_stage_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
